// File: hw/shadow_config.svh
// Register count, widths and address map of the shadow register block, included where needed
`ifndef SHADOW_CONFIG_SVH
`define SHADOW_CONFIG_SVH

// ====================
// Register bank size
// ====================
`define SHADOW_NUM_REGS     4   // Parameter registers
`define SHADOW_DATA_WIDTH   32  // Bits per parameter

// ====================
// Command port
// ====================
`define SHADOW_ADDR_WIDTH   4   // Command address width
`define SHADOW_INDEX_WIDTH  2   // Update index, wraps modulo 4

// Staging registers sit at 0 to NUM_REGS-1, active values from here up
`define SHADOW_ACTIVE_BASE  4

`endif

// File: hw/shadow_pkg.sv
// Shared command, response and parameter bank types for the shadow register block
`include "shadow_config.svh"

package shadow_pkg;

    // ====================
    // Host command port
    // ====================
    typedef enum logic [1:0] {
        REG_NOP   = 2'd0,
        REG_WRITE = 2'd1,
        REG_READ  = 2'd2
    } reg_op_t;

    // One command per reg_clk cycle
    typedef struct packed {
        reg_op_t                        op;
        logic [`SHADOW_ADDR_WIDTH-1:0]  addr;
        logic [`SHADOW_DATA_WIDTH-1:0]  wdata;
    } reg_cmd_t;

    typedef struct packed {
        logic                           rvalid;  // Pulses two cycles after a read
        logic [`SHADOW_DATA_WIDTH-1:0]  rdata;
    } reg_rsp_t;

    // ====================
    // Core side
    // ====================
    // Active parameters as the core sees them, word i is register i
    typedef logic [`SHADOW_NUM_REGS-1:0][`SHADOW_DATA_WIDTH-1:0] param_bank_t;

endpackage

// File: hw/reg_cmd_decoder.sv
// Host command decoder, turns reg_cmd into staging write strobes and a registered read select
`timescale 1ns/1ps
`include "shadow_config.svh"

module reg_cmd_decoder (
    input  logic                            reg_clk,
    input  logic                            reg_reset,
    input  shadow_pkg::reg_cmd_t            cmd,
    output logic [`SHADOW_NUM_REGS-1:0]     wr_en,
    output logic [`SHADOW_DATA_WIDTH-1:0]   wr_data,
    output logic [`SHADOW_ADDR_WIDTH-1:0]   rd_sel,
    output logic                            rd_en
);
    import shadow_pkg::*;

    localparam int unsigned ADDR_W = `SHADOW_ADDR_WIDTH;

    // ====================
    // Write path
    // ====================
    // One-hot strobe, only staging addresses can match
    always_comb begin
        wr_en = '0;
        for (int i = 0; i < `SHADOW_NUM_REGS; i++) begin
            wr_en[i] = (cmd.op == REG_WRITE) && (cmd.addr == ADDR_W'(i));
        end
    end

    assign wr_data = cmd.wdata;  // Shared by all channels

    // ====================
    // Read path
    // ====================
    always_ff @(posedge reg_clk) begin
        if (reg_reset) begin
            rd_en <= 1'b0;
        end else begin
            rd_en <= (cmd.op == REG_READ);
        end
    end

    // Address is only looked at when rd_en is high
    always_ff @(posedge reg_clk) begin
        rd_sel <= cmd.addr;
    end

endmodule

// File: hw/shadow_channel.sv
// One shadowed parameter, a staging copy written by the host and an active copy for the core
`timescale 1ns/1ps
`include "shadow_config.svh"

module shadow_channel (
    input  logic                            reg_clk,
    input  logic                            reg_reset,
    input  logic                            wr_en,
    input  logic [`SHADOW_DATA_WIDTH-1:0]   wr_data,
    input  logic                            core_clk,
    input  logic                            core_reset,
    input  logic                            core_update,
    output logic [`SHADOW_DATA_WIDTH-1:0]   staged,
    output logic [`SHADOW_DATA_WIDTH-1:0]   active
);

    // Staging copy in the host domain
    always_ff @(posedge reg_clk) begin
        if (reg_reset) begin
            staged <= '0;
        end else if (wr_en) begin
            staged <= wr_data;
        end
    end

    // Active copy captures staged across the clock boundary.
    // The host leaves staged alone from request until acknowledge,
    // so the value is stable whenever core_update is high.
    (* ASYNC_REG = "true" *) logic [`SHADOW_DATA_WIDTH-1:0] active_q;

    always_ff @(posedge core_clk) begin
        if (core_reset || core_update) begin  // Reset loads the zero staging values
            active_q <= staged;
        end
    end

    assign active = active_q;

endmodule

// File: hw/shadow_update_ctl.sv
// Update handshake between host and core, level request in, index pulse acknowledge back
`timescale 1ns/1ps

module shadow_update_ctl #(
    parameter int INDEX_WIDTH = 2
) (
    input  logic                    reg_clk,
    input  logic                    reg_reset,
    input  logic                    update_req,
    output logic                    update_ack,
    output logic [INDEX_WIDTH-1:0]  index,
    input  logic                    core_clk,
    input  logic                    core_reset,
    input  logic                    core_acceptable,
    output logic                    core_update
);

    // ====================
    // Request into core_clk
    // ====================
    (* ASYNC_REG = "true" *) logic req_sync0;
    (* ASYNC_REG = "true" *) logic req_sync1;

    always_ff @(posedge core_clk) begin
        if (core_reset) begin
            req_sync0 <= 1'b0;
            req_sync1 <= 1'b0;
        end else begin
            req_sync0 <= update_req;
            req_sync1 <= req_sync0;
        end
    end

    logic accept;
    assign accept = req_sync1 && core_acceptable;

    // Counts accepted updates, core side
    logic [INDEX_WIDTH-1:0] core_index;

    always_ff @(posedge core_clk) begin
        if (core_reset) begin
            core_index <= '0;
        end else if (accept) begin
            core_index <= core_index + 1'b1;
        end
    end

    assign core_update = core_reset || accept;  // Reset loads the zero staging values

    // ====================
    // Index back into reg_clk
    // ====================
    // Index moves by one per update, so only bit 0 needs to be compared
    (* ASYNC_REG = "true" *) logic [INDEX_WIDTH-1:0] idx_sync0;
    (* ASYNC_REG = "true" *) logic [INDEX_WIDTH-1:0] idx_sync1;
    (* ASYNC_REG = "true" *) logic                   idx_sync2;

    always_ff @(posedge reg_clk) begin
        if (reg_reset) begin
            idx_sync0 <= '0;
            idx_sync1 <= '0;
            idx_sync2 <= 1'b0;
        end else begin
            idx_sync0 <= core_index;
            idx_sync1 <= idx_sync0;
            idx_sync2 <= idx_sync1[0];
        end
    end

    assign update_ack = (idx_sync2 != idx_sync1[0]);  // One cycle per change
    assign index      = idx_sync1;

endmodule

// File: hw/reg_readback_mux.sv
// Registered readback of the staging and active parameters onto the host response
`timescale 1ns/1ps
`include "shadow_config.svh"

module reg_readback_mux (
    input  logic                            reg_clk,
    input  logic                            reg_reset,
    input  logic                            rd_en,
    input  logic [`SHADOW_ADDR_WIDTH-1:0]   rd_sel,
    input  shadow_pkg::param_bank_t         staged,
    input  shadow_pkg::param_bank_t         active,
    output shadow_pkg::reg_rsp_t            rsp
);

    localparam int unsigned ADDR_W = `SHADOW_ADDR_WIDTH;

    logic [`SHADOW_DATA_WIDTH-1:0] sel_data;
    logic [`SHADOW_DATA_WIDTH-1:0] rdata_q;
    logic                          rvalid_q;

    // Unmapped addresses fall through to zero
    always_comb begin
        sel_data = '0;
        for (int i = 0; i < `SHADOW_NUM_REGS; i++) begin
            if (rd_sel == ADDR_W'(i)) begin
                sel_data = staged[i];
            end
            if (rd_sel == ADDR_W'(`SHADOW_ACTIVE_BASE + i)) begin
                sel_data = active[i];  // Read only window
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (reg_reset) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_en;
        end
    end

    always_ff @(posedge reg_clk) begin
        rdata_q <= sel_data;
    end

    assign rsp = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

// File: hw/shadow_reg_top.sv
// Shadow register block top, host command port in reg_clk and active parameters in core_clk
`timescale 1ns/1ps
`include "shadow_config.svh"

module shadow_reg_top (
    input  logic                            reg_clk,
    input  logic                            reg_reset,
    input  shadow_pkg::reg_cmd_t            reg_cmd,
    output shadow_pkg::reg_rsp_t            reg_rsp,
    input  logic                            update_req,
    output logic                            update_ack,
    output logic [`SHADOW_INDEX_WIDTH-1:0]  update_index,
    input  logic                            core_clk,
    input  logic                            core_reset,
    input  logic                            core_acceptable,
    output logic                            core_update,
    output shadow_pkg::param_bank_t         core_params
);
    import shadow_pkg::*;

    logic [`SHADOW_NUM_REGS-1:0]    wr_en;
    logic [`SHADOW_DATA_WIDTH-1:0]  wr_data;
    logic [`SHADOW_ADDR_WIDTH-1:0]  rd_sel;
    logic                           rd_en;
    param_bank_t                    staged_bank;  // Host side copies for readback

    // ====================
    // Host command decode
    // ====================
    reg_cmd_decoder u_decoder (
        .reg_clk   (reg_clk),
        .reg_reset (reg_reset),
        .cmd       (reg_cmd),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .rd_sel    (rd_sel),
        .rd_en     (rd_en)
    );

    // ====================
    // Parameter channels
    // ====================
    for (genvar i = 0; i < `SHADOW_NUM_REGS; i++) begin : g_chan
        shadow_channel u_chan (
            .reg_clk     (reg_clk),
            .reg_reset   (reg_reset),
            .wr_en       (wr_en[i]),
            .wr_data     (wr_data),
            .core_clk    (core_clk),
            .core_reset  (core_reset),
            .core_update (core_update),
            .staged      (staged_bank[i]),
            .active      (core_params[i])
        );
    end

    // Update handshake
    shadow_update_ctl #(
        .INDEX_WIDTH (`SHADOW_INDEX_WIDTH)
    ) u_update_ctl (
        .reg_clk         (reg_clk),
        .reg_reset       (reg_reset),
        .update_req      (update_req),
        .update_ack      (update_ack),
        .index           (update_index),
        .core_clk        (core_clk),
        .core_reset      (core_reset),
        .core_acceptable (core_acceptable),
        .core_update     (core_update)
    );

    reg_readback_mux u_readback (
        .reg_clk   (reg_clk),
        .reg_reset (reg_reset),
        .rd_en     (rd_en),
        .rd_sel    (rd_sel),
        .staged    (staged_bank),
        .active    (core_params),  // Read across the clock boundary, stable between updates
        .rsp       (reg_rsp)
    );

endmodule

// File: test/tb_clock_gen.sv
// Testbench clock and synchronous reset source, one instance per clock domain
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD       = 4.0,
    parameter real PHASE        = 0.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        #(PHASE);
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;  // Released just after an edge
    end

endmodule

// File: test/shadow_reg_asserts.sv
// Handshake assertions for the update controller, attached to every shadow_update_ctl by bind
`timescale 1ns/1ps

module shadow_reg_asserts #(
    parameter int INDEX_WIDTH = 2
) (
    input logic                   reg_clk,
    input logic                   reg_reset,
    input logic                   update_req,
    input logic                   update_ack,
    input logic [INDEX_WIDTH-1:0] index,
    input logic                   core_clk,
    input logic                   core_reset,
    input logic                   core_acceptable,
    input logic                   core_update
);

    ack_one_cycle: assert property (@(posedge reg_clk) disable iff (reg_reset)
        update_ack |=> !update_ack)
        else $error("update_ack held for more than one reg_clk cycle");

    // The core may delay an update but only takes one it accepted while the host requests it
    update_needs_acceptable: assert property (@(posedge core_clk) disable iff (core_reset)
        core_update |-> (core_acceptable && update_req))
        else $error("core_update without core_acceptable and a pending update_req");

    index_steps_by_one: assert property (@(posedge reg_clk) disable iff (reg_reset)
        (index != $past(index)) |-> (index == INDEX_WIDTH'($past(index) + 1'b1)))
        else $error("update index moved by more than one");

endmodule

bind shadow_update_ctl shadow_reg_asserts #(
    .INDEX_WIDTH (INDEX_WIDTH)
) u_asserts (
    .reg_clk         (reg_clk),
    .reg_reset       (reg_reset),
    .update_req      (update_req),
    .update_ack      (update_ack),
    .index           (index),
    .core_clk        (core_clk),
    .core_reset      (core_reset),
    .core_acceptable (core_acceptable),
    .core_update     (core_update)
);

// File: test/shadow_reg_checker.sv
// Reference model and scoreboard, watches the DUT ports and compares reads, params and index
`timescale 1ns/1ps
`include "shadow_config.svh"

module shadow_reg_checker (
    input logic                             reg_clk,
    input logic                             reg_reset,
    input shadow_pkg::reg_cmd_t             reg_cmd,
    input shadow_pkg::reg_rsp_t             reg_rsp,
    input logic                             update_req,
    input logic                             update_ack,
    input logic [`SHADOW_INDEX_WIDTH-1:0]   update_index,
    input logic                             core_clk,
    input logic                             core_reset,
    input logic                             core_acceptable,
    input logic                             core_update,
    input shadow_pkg::param_bank_t          core_params,
    input logic                             ack_allowed
);
    import shadow_pkg::*;

    localparam int N    = `SHADOW_NUM_REGS;
    localparam int BASE = `SHADOW_ACTIVE_BASE;

    logic [`SHADOW_DATA_WIDTH-1:0]  staging [N];
    logic [`SHADOW_DATA_WIDTH-1:0]  active [N];
    logic [`SHADOW_DATA_WIDTH-1:0]  exp_q [2];  // Read pipeline, two reg_clk deep
    logic                           vld_q [2];
    logic [`SHADOW_INDEX_WIDTH-1:0] exp_index;
    logic [1:0]                     req_seen;   // Request as the core sees it two edges later
    int error_count = 0;
    int test_errors = 0;
    int tests_done  = 0;

    function automatic logic [31:0] expected_read(input logic [3:0] addr);
        if (addr < N) return staging[addr];
        if (addr >= BASE && addr < BASE + N) return active[addr - BASE];
        return '0;  // Unmapped
    endfunction

    task automatic report_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
        $display("error t=%0t %s got=%h expected=%h", $time, sig, got, exp);
        error_count++;
        test_errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("failure at t=%0t: %s", $time, msg);
        error_count++;
        test_errors++;
    endtask

    task automatic check_params();
        for (int i = 0; i < N; i++) begin
            if (core_params[i] !== active[i])
                report_value($sformatf("core_params[%0d]", i), core_params[i], active[i]);
        end
    endtask

    task automatic end_test(input int id);
        $display("test %0d %s, %0d errors", id, (test_errors == 0) ? "ok" : "failed", test_errors);
        tests_done++;
        test_errors = 0;
    endtask

    task automatic summary();
        $display("%0d tests run, %0d errors", tests_done, error_count);
    endtask

    // Sampled at the edge, so values are the settled pre-edge ones
    always @(posedge reg_clk) begin
        if (reg_reset) begin
            for (int i = 0; i < N; i++) begin
                staging[i] = '0;
                active[i]  = '0;
            end
            vld_q     = '{1'b0, 1'b0};
            exp_q     = '{32'h0, 32'h0};
            exp_index = '0;
        end else begin
            if (reg_rsp.rvalid !== vld_q[1]) report_value("rvalid", reg_rsp.rvalid, vld_q[1]);
            else if (vld_q[1] && reg_rsp.rdata !== exp_q[1])
                report_value("rdata", reg_rsp.rdata, exp_q[1]);
            vld_q[1] = vld_q[0];
            exp_q[1] = exp_q[0];
            vld_q[0] = (reg_cmd.op == REG_READ);
            exp_q[0] = expected_read(reg_cmd.addr);
            if (reg_cmd.op == REG_WRITE && reg_cmd.addr < N) staging[reg_cmd.addr] = reg_cmd.wdata;
            if (update_ack) begin
                if (!ack_allowed) note_failure("update_ack arrived without an accepted update");
                for (int i = 0; i < N; i++) active[i] = staging[i];
                exp_index++;
                if (update_index !== exp_index) report_value("update_index", update_index, exp_index);
            end
        end
    end

    // Core side, an update is due in reset or when an old enough request meets acceptable
    always @(posedge core_clk) begin
        if (core_reset) begin
            if (core_update !== 1'b1) report_value("core_update", core_update, 1'b1);
            req_seen = '0;
        end else begin
            if (core_update !== (core_acceptable && req_seen[1]))
                report_value("core_update", core_update, core_acceptable && req_seen[1]);
            req_seen = {req_seen[0], update_req};
        end
    end

endmodule

// File: test/shadow_reg_tb.sv
// Testbench top, applies the stimulus table to shadow_reg_top and prints the verdict
`timescale 1ns/1ps
`include "shadow_config.svh"

module shadow_reg_tb;
    import shadow_pkg::*;

    typedef enum logic [1:0] {T_WRITE, T_WRITE_RAND, T_READ, T_UPDATE} step_op_t;

    typedef struct packed {
        int          test;
        step_op_t    op;
        logic [3:0]  addr;
        logic [31:0] data;     // Write data, or core cycles to hold the request
        logic [31:0] exp_val;  // Update index after the acknowledge
    } step_t;

    localparam logic [31:0] SEED = 32'hb964191e;

    logic core_clk, core_reset, reg_clk, reg_reset;
    logic update_req, update_ack, core_acceptable, core_update, ack_allowed;
    logic [`SHADOW_INDEX_WIDTH-1:0] update_index;
    reg_cmd_t    reg_cmd;
    reg_rsp_t    reg_rsp;
    param_bank_t core_params;
    step_t       steps[$];
    int          cycle_count = 0;
    int          timeout_limit = 1000000;

    tb_clock_gen #(.PERIOD(4.0)) u_core_clk (.clk(core_clk), .reset(core_reset));
    // Half ns offset keeps reg_clk edges clear of core_clk edges
    tb_clock_gen #(.PERIOD(6.0), .PHASE(0.5)) u_reg_clk (.clk(reg_clk), .reset(reg_reset));

    shadow_reg_top uut (
        .reg_clk(reg_clk), .reg_reset(reg_reset), .reg_cmd(reg_cmd), .reg_rsp(reg_rsp),
        .update_req(update_req), .update_ack(update_ack), .update_index(update_index),
        .core_clk(core_clk), .core_reset(core_reset), .core_acceptable(core_acceptable),
        .core_update(core_update), .core_params(core_params)
    );

    shadow_reg_checker u_chk (
        .reg_clk(reg_clk), .reg_reset(reg_reset), .reg_cmd(reg_cmd), .reg_rsp(reg_rsp),
        .update_req(update_req), .update_ack(update_ack), .update_index(update_index),
        .core_clk(core_clk), .core_reset(core_reset), .core_acceptable(core_acceptable),
        .core_update(core_update), .core_params(core_params), .ack_allowed(ack_allowed)
    );

    task automatic add_step(input int t, input step_op_t op, input logic [3:0] a,
                            input logic [31:0] d, input logic [31:0] e);
        steps.push_back('{t, op, a, d, e});
    endtask

    task automatic drive_cmd(input reg_op_t op, input logic [3:0] a, input logic [31:0] d);
        @(posedge reg_clk);
        #1 reg_cmd = '{op: op, addr: a, wdata: d};
        @(posedge reg_clk);
        #1 reg_cmd = '{op: REG_NOP, addr: '0, wdata: '0};
    endtask

    task automatic run_update(input step_t s);
        @(posedge reg_clk);
        #1 update_req = 1'b1;
        repeat (s.data) @(posedge core_clk);  // Held with core_acceptable low
        u_chk.check_params();
        #1 core_acceptable = 1'b1;
        ack_allowed = 1'b1;
        @(posedge core_clk);
        #1 core_acceptable = 1'b0;
        do @(negedge reg_clk); while (!update_ack);
        @(posedge reg_clk);
        #1 update_req = 1'b0;
        ack_allowed = 1'b0;
        u_chk.check_params();
        if (update_index !== s.exp_val[`SHADOW_INDEX_WIDTH-1:0])
            u_chk.report_value("update_index", update_index, s.exp_val);
        repeat (20) @(posedge core_clk);  // Spacing between rounds
    endtask

    task automatic apply_step(input step_t s);
        case (s.op)
            T_WRITE:      drive_cmd(REG_WRITE, s.addr, s.data);
            T_WRITE_RAND: drive_cmd(REG_WRITE, s.addr, $urandom());
            T_READ:       drive_cmd(REG_READ, s.addr, '0);
            T_UPDATE:     run_update(s);
        endcase
    endtask

    // ====================
    // Timeout
    // ====================
    always @(posedge core_clk) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run did not finish within %0d core_clk cycles", timeout_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        reg_cmd = '{op: REG_NOP, addr: '0, wdata: '0};
        update_req = 1'b0;
        core_acceptable = 1'b0;
        ack_allowed = 1'b0;
        // ====================
        // Stimulus table
        // ====================
        add_step(1, T_READ, 0, 0, 0);
        add_step(1, T_READ, 5, 0, 0);
        add_step(1, T_READ, 12, 0, 0);
        add_step(2, T_WRITE_RAND, 0, 0, 0);
        add_step(2, T_WRITE_RAND, 1, 0, 0);
        add_step(2, T_WRITE_RAND, 2, 0, 0);
        add_step(2, T_WRITE_RAND, 3, 0, 0);
        add_step(2, T_READ, 0, 0, 0);
        add_step(2, T_READ, 3, 0, 0);
        add_step(3, T_UPDATE, 0, 30, 1);  // Long hold before the core accepts
        add_step(3, T_READ, 4, 0, 0);
        add_step(3, T_READ, 7, 0, 0);
        add_step(4, T_WRITE, 9, 32'hdeadbeef, 0);
        add_step(4, T_READ, 9, 0, 0);
        add_step(4, T_READ, 1, 0, 0);  // Staging alias of address 9 must be untouched
        add_step(5, T_WRITE_RAND, 1, 0, 0);
        add_step(5, T_UPDATE, 0, 20, 2);
        add_step(5, T_READ, 5, 0, 0);
        add_step(5, T_WRITE_RAND, 2, 0, 0);
        add_step(5, T_UPDATE, 0, 20, 3);
        add_step(5, T_READ, 6, 0, 0);
        add_step(5, T_WRITE_RAND, 3, 0, 0);
        add_step(5, T_UPDATE, 0, 20, 0);  // Index wraps
        add_step(5, T_READ, 7, 0, 0);
        timeout_limit = steps.size() * 200;

        wait (!reg_reset && !core_reset);
        @(posedge reg_clk);
        u_chk.check_params();
        if (update_index !== '0) u_chk.report_value("update_index", update_index, 0);
        for (int i = 0; i < steps.size(); i++) begin
            apply_step(steps[i]);
            if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
                repeat (3) @(posedge reg_clk);  // Drain the read pipeline
                u_chk.end_test(steps[i].test);
            end
        end
        u_chk.summary();
        if (u_chk.error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+hw
hw/shadow_pkg.sv
hw/reg_cmd_decoder.sv
hw/shadow_channel.sv
hw/shadow_update_ctl.sv
hw/reg_readback_mux.sv
hw/shadow_reg_top.sv
test/tb_clock_gen.sv
test/shadow_reg_asserts.sv
test/shadow_reg_checker.sv
test/shadow_reg_tb.sv
